// ==== common/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  localparam int XLEN_DEFAULT = 32;

  typedef logic [4:0] exec_op_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [5:0] shamt_t;

  // Single-cycle operations.
  localparam exec_op_t OP_ADD   = 5'd0;
  localparam exec_op_t OP_SUB   = 5'd1;
  localparam exec_op_t OP_AND   = 5'd2;
  localparam exec_op_t OP_OR    = 5'd3;
  localparam exec_op_t OP_XOR   = 5'd4;
  localparam exec_op_t OP_SLL   = 5'd5;
  localparam exec_op_t OP_SRL   = 5'd6;
  localparam exec_op_t OP_SRA   = 5'd7;
  localparam exec_op_t OP_SLT   = 5'd8;
  localparam exec_op_t OP_SLTU  = 5'd9;
  localparam exec_op_t OP_LUI   = 5'd10;
  localparam exec_op_t OP_AUIPC = 5'd11;
  localparam exec_op_t OP_LINK  = 5'd12; // jal and jalr.

  // Iterative unit.
  localparam exec_op_t OP_MUL   = 5'd16;
  localparam exec_op_t OP_MULHU = 5'd17;
  localparam exec_op_t OP_DIVU  = 5'd18;
  localparam exec_op_t OP_REMU  = 5'd19;

  typedef enum logic [1:0] {
    IDLE,
    MULDIV,
    HOLD
  } ctrl_state_e;

  typedef enum logic [1:0] {
    MD_MUL,
    MD_MULHU,
    MD_DIVU,
    MD_REMU
  } muldiv_op_e;

  localparam ctrl_state_e STATE_RST = IDLE;
  localparam muldiv_op_e  MD_OP_RST = MD_MUL;
  localparam reg_addr_t   WADDR_RST = '0;

  function automatic logic is_muldiv(exec_op_t op);
    return op inside {OP_MUL, OP_MULHU, OP_DIVU, OP_REMU};
  endfunction

endpackage

`default_nettype wire

// ==== common/muldiv_if.sv ====
`default_nettype none

interface muldiv_if #(
  parameter int XLEN = exec_pkg::XLEN_DEFAULT
);
  logic                 start;
  logic                 step;
  exec_pkg::muldiv_op_e op;
  logic [XLEN-1:0]      operand_a;
  logic [XLEN-1:0]      operand_b;
  logic [XLEN-1:0]      result;

  modport ctrl (output start, output step);

  modport unit (
    input  start,
    input  step,
    input  op,
    input  operand_a,
    input  operand_b,
    output result
  );

  // Start marks acceptance, so the sink can capture the destination.
  modport sink (input start, input result);

endinterface

`default_nettype wire

// ==== execute/execute_ctrl.sv ====
`default_nettype none

module execute_ctrl #(
  parameter int XLEN = exec_pkg::XLEN_DEFAULT
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  exec_pkg::exec_op_t in_op,
  output logic               in_ready,
  output logic               out_valid,
  input  logic               out_ready,
  output logic               count_load,
  input  logic               count_done,
  output logic               load_alu,
  output logic               load_muldiv,
  output logic               wb_release,
  muldiv_if.ctrl             md
);

  exec_pkg::ctrl_state_e state_q;
  exec_pkg::ctrl_state_e state_d;
  logic                  accept;
  logic                  to_md;

  always_comb begin
    out_valid = (state_q == exec_pkg::HOLD);
    wb_release = out_valid && out_ready;
    in_ready = (state_q == exec_pkg::IDLE) || wb_release; // Take a new one as the old leaves.
    accept = in_valid && in_ready;
    to_md = exec_pkg::is_muldiv(in_op);

    load_alu = accept && !to_md;
    md.start = accept && to_md;
    count_load = accept && to_md;
    md.step = (state_q == exec_pkg::MULDIV) && !count_done;
    load_muldiv = (state_q == exec_pkg::MULDIV) && count_done;

    state_d = state_q;
    case (state_q)
      exec_pkg::MULDIV: begin
        if (count_done) begin
          state_d = exec_pkg::HOLD;
        end
      end
      default: begin
        if (accept) begin
          state_d = to_md ? exec_pkg::MULDIV : exec_pkg::HOLD;
        end else if (wb_release) begin
          state_d = exec_pkg::IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q <= exec_pkg::STATE_RST;
    end else begin
      state_q <= state_d;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (!rst)
    (out_valid && !out_ready) |=> out_valid);

  // Counter and unit together give the full mul/div latency.
  a_md_latency: assert property (@(posedge clk) disable iff (!rst)
    md.start |=> !out_valid [*(XLEN+1)] ##1 out_valid);

endmodule

`default_nettype wire

// ==== execute/execute_top.sv ====
`default_nettype none

module execute_top #(
  parameter int XLEN = exec_pkg::XLEN_DEFAULT
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  exec_pkg::exec_op_t  in_op,
  input  logic                in_use_imm,
  input  logic [XLEN-1:0]     in_rdata1,
  input  logic [XLEN-1:0]     in_rdata2,
  input  logic [XLEN-1:0]     in_imm,
  input  logic [XLEN-1:0]     in_pc,
  input  logic [XLEN-1:0]     in_npc,
  input  exec_pkg::reg_addr_t in_waddr,
  output logic                out_valid,
  input  logic                out_ready,
  output logic                out_wren,
  output exec_pkg::reg_addr_t out_waddr,
  output logic [XLEN-1:0]     out_wdata
);

  logic            count_load;
  logic            count_done;
  logic            load_alu;
  logic            load_muldiv;
  logic            wb_release;
  logic [XLEN-1:0] alu_wdata;

  muldiv_if #(.XLEN(XLEN)) md ();

  // Register forms only, so both operands come from the register file.
  assign md.operand_a = in_rdata1;
  assign md.operand_b = in_rdata2;

  always_comb begin
    case (in_op)
      exec_pkg::OP_MULHU: md.op = exec_pkg::MD_MULHU;
      exec_pkg::OP_DIVU:  md.op = exec_pkg::MD_DIVU;
      exec_pkg::OP_REMU:  md.op = exec_pkg::MD_REMU;
      default:            md.op = exec_pkg::MD_MUL;
    endcase
  end

  execute_ctrl #(.XLEN(XLEN)) i_ctrl (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .count_load (count_load),
    .count_done (count_done),
    .load_alu   (load_alu),
    .load_muldiv(load_muldiv),
    .wb_release (wb_release),
    .md         (md.ctrl)
  );

  iter_counter #(.XLEN(XLEN)) i_counter (
    .clk (clk),
    .rst (rst),
    .load(count_load),
    .done(count_done)
  );

  muldiv_unit #(.XLEN(XLEN)) i_muldiv (
    .clk(clk),
    .rst(rst),
    .md (md.unit)
  );

  int_alu #(.XLEN(XLEN)) i_alu (
    .op       (in_op),
    .use_imm  (in_use_imm),
    .rdata1   (in_rdata1),
    .rdata2   (in_rdata2),
    .imm      (in_imm),
    .pc       (in_pc),
    .npc      (in_npc),
    .alu_wdata(alu_wdata)
  );

  writeback_reg #(.XLEN(XLEN)) i_wb (
    .clk        (clk),
    .rst        (rst),
    .load_alu   (load_alu),
    .load_muldiv(load_muldiv),
    .wb_release (wb_release),
    .in_waddr   (in_waddr),
    .alu_wdata  (alu_wdata),
    .md         (md.sink),
    .out_wren   (out_wren),
    .out_waddr  (out_waddr),
    .out_wdata  (out_wdata)
  );

endmodule

`default_nettype wire

// ==== execute/muldiv_unit.sv ====
`default_nettype none

module muldiv_unit #(
  parameter int XLEN = exec_pkg::XLEN_DEFAULT
) (
  input  logic   clk,
  input  logic   rst,
  muldiv_if.unit md
);

  exec_pkg::muldiv_op_e op_q;
  logic [2*XLEN-1:0]    acc_q;      // Multiply {high, low}, divide {remainder, quotient}.
  logic [XLEN-1:0]      divisor_q;  // Also the multiplicand.
  logic                 is_div;
  logic [XLEN:0]        add_sum;
  logic [XLEN:0]        rem_shift;
  logic [XLEN:0]        trial;
  logic [2*XLEN-1:0]    acc_mul;
  logic [2*XLEN-1:0]    acc_div;

  always_comb begin
    is_div = (op_q == exec_pkg::MD_DIVU) || (op_q == exec_pkg::MD_REMU);

    // Shift-add step.
    add_sum = {1'b0, acc_q[2*XLEN-1:XLEN]} + {1'b0, divisor_q & {XLEN{acc_q[0]}}};
    acc_mul = {add_sum, acc_q[XLEN-1:1]};

    // Restoring divide step.
    rem_shift = acc_q[2*XLEN-1:XLEN-1];
    trial = rem_shift - {1'b0, divisor_q};
    if (trial[XLEN]) begin
      acc_div = {rem_shift[XLEN-1:0], acc_q[XLEN-2:0], 1'b0}; // Borrow, restore.
    end else begin
      acc_div = {trial[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      op_q <= exec_pkg::MD_OP_RST;
    end else if (md.start) begin
      op_q <= md.op;
    end
  end

  always_ff @(posedge clk) begin
    if (md.start) begin
      acc_q <= {{XLEN{1'b0}}, md.operand_a};
      divisor_q <= md.operand_b;
    end else if (md.step) begin
      acc_q <= is_div ? acc_div : acc_mul;
    end
  end

  always_comb begin
    case (op_q)
      exec_pkg::MD_MULHU: md.result = acc_q[2*XLEN-1:XLEN];
      exec_pkg::MD_REMU:  md.result = acc_q[2*XLEN-1:XLEN];
      default:            md.result = acc_q[XLEN-1:0]; // Low product or quotient.
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/int_alu.sv ====
`default_nettype none

module int_alu #(
  parameter int XLEN = exec_pkg::XLEN_DEFAULT
) (
  input  exec_pkg::exec_op_t op,
  input  logic               use_imm,
  input  logic [XLEN-1:0]    rdata1,
  input  logic [XLEN-1:0]    rdata2,
  input  logic [XLEN-1:0]    imm,
  input  logic [XLEN-1:0]    pc,
  input  logic [XLEN-1:0]    npc,
  output logic [XLEN-1:0]    alu_wdata
);

  localparam int SW = $clog2(XLEN);

  logic [XLEN-1:0]  opb;
  exec_pkg::shamt_t shamt;
  logic [SW-1:0]    sh;

  always_comb begin
    opb = use_imm ? imm : rdata2;
    shamt = opb[5:0];
    sh = shamt[SW-1:0]; // 5 bits at 32, 6 at 64.

    case (op)
      exec_pkg::OP_ADD:   alu_wdata = rdata1 + opb;
      exec_pkg::OP_SUB:   alu_wdata = rdata1 - opb;
      exec_pkg::OP_AND:   alu_wdata = rdata1 & opb;
      exec_pkg::OP_OR:    alu_wdata = rdata1 | opb;
      exec_pkg::OP_XOR:   alu_wdata = rdata1 ^ opb;
      exec_pkg::OP_SLL:   alu_wdata = rdata1 << sh;
      exec_pkg::OP_SRL:   alu_wdata = rdata1 >> sh;
      exec_pkg::OP_SRA:   alu_wdata = $unsigned($signed(rdata1) >>> sh);
      exec_pkg::OP_SLT:   alu_wdata = XLEN'($signed(rdata1) < $signed(opb));
      exec_pkg::OP_SLTU:  alu_wdata = XLEN'(rdata1 < opb);
      exec_pkg::OP_LUI:   alu_wdata = imm;
      exec_pkg::OP_AUIPC: alu_wdata = pc + imm;
      exec_pkg::OP_LINK:  alu_wdata = npc; // Return address.
      default:            alu_wdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/iter_counter.sv ====
`default_nettype none

module iter_counter #(
  parameter int XLEN = exec_pkg::XLEN_DEFAULT
) (
  input  logic clk,
  input  logic rst,
  input  logic load,
  output logic done
);

  localparam int CW = $clog2(XLEN + 1);

  logic [CW-1:0] count_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      count_q <= '0;
      done <= 1'b0;
    end else begin
      done <= (count_q == CW'(1)); // Registered so it follows the last step.
      if (load) begin
        count_q <= CW'(XLEN);
      end else if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  a_load_idle: assert property (@(posedge clk) disable iff (!rst)
    load |-> (count_q == '0));

endmodule

`default_nettype wire

// ==== logic/writeback_reg.sv ====
`default_nettype none

module writeback_reg #(
  parameter int XLEN = exec_pkg::XLEN_DEFAULT
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                load_alu,
  input  logic                load_muldiv,
  input  logic                wb_release,
  input  exec_pkg::reg_addr_t in_waddr,
  input  logic [XLEN-1:0]     alu_wdata,
  muldiv_if.sink              md,
  output logic                out_wren,
  output exec_pkg::reg_addr_t out_waddr,
  output logic [XLEN-1:0]     out_wdata
);

  always_ff @(posedge clk) begin
    if (!rst) begin
      out_wren <= 1'b0;
      out_waddr <= exec_pkg::WADDR_RST;
    end else begin
      if (load_alu || md.start) begin
        out_waddr <= in_waddr; // Destination taken at acceptance.
      end
      // x0 never writes.
      if (load_alu) begin
        out_wren <= |in_waddr;
      end else if (load_muldiv) begin
        out_wren <= |out_waddr;
      end else if (wb_release) begin
        out_wren <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_alu) begin
      out_wdata <= alu_wdata;
    end else if (load_muldiv) begin
      out_wdata <= md.result;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
common/exec_pkg.sv
common/muldiv_if.sv
logic/int_alu.sv
logic/iter_counter.sv
logic/writeback_reg.sv
execute/execute_ctrl.sv
execute/muldiv_unit.sv
execute/execute_top.sv
sim/tb_execute_top.sv

// ==== sim/tb_execute_top.sv ====
`default_nettype none

module tb_execute_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int XLEN = exec_pkg::XLEN_DEFAULT;
  localparam int CLK_PERIOD = 4;
  localparam int N_ALU = 40;
  localparam int N_UPPER = 6;
  localparam int N_MUL = 12;
  localparam int N_DIV = 12;
  localparam int N_X0 = 4;
  localparam int N_BP = 30;
  localparam int N_TOTAL = N_ALU + N_UPPER + N_MUL + N_DIV + N_X0 + N_BP;
  localparam int WATCHDOG_NS = (N_TOTAL * (XLEN + 3) * 4 + 8) * CLK_PERIOD;

  logic                clk;
  logic                rst;
  logic                in_valid;
  logic                in_ready;
  exec_pkg::exec_op_t  in_op;
  logic                in_use_imm;
  logic [XLEN-1:0]     in_rdata1;
  logic [XLEN-1:0]     in_rdata2;
  logic [XLEN-1:0]     in_imm;
  logic [XLEN-1:0]     in_pc;
  logic [XLEN-1:0]     in_npc;
  exec_pkg::reg_addr_t in_waddr;
  logic                out_valid;
  logic                out_ready;
  logic                out_wren;
  exec_pkg::reg_addr_t out_waddr;
  logic [XLEN-1:0]     out_wdata;

  logic [XLEN-1:0]     exp_data[$];
  exec_pkg::reg_addr_t exp_addr[$];
  logic                exp_wren[$];
  logic [31:0]         lfsr_q = 32'd33;
  logic                random_ready = 1'b0;
  logic                md_busy = 1'b0;
  int                  errors = 0;
  int                  n_checks = 0;

  execute_top #(.XLEN(XLEN)) i_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_op     (in_op),
    .in_use_imm(in_use_imm),
    .in_rdata1 (in_rdata1),
    .in_rdata2 (in_rdata2),
    .in_imm    (in_imm),
    .in_pc     (in_pc),
    .in_npc    (in_npc),
    .in_waddr  (in_waddr),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_wren  (out_wren),
    .out_waddr (out_waddr),
    .out_wdata (out_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Taps 32, 22, 2, 1.
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic logic [XLEN-1:0] ref_result(input exec_pkg::exec_op_t op,
                                                 input logic use_imm,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b,
                                                 input logic [XLEN-1:0] imm,
                                                 input logic [XLEN-1:0] pc,
                                                 input logic [XLEN-1:0] npc);
    logic [XLEN-1:0]   opb;
    logic [XLEN-1:0]   r;
    logic [2*XLEN-1:0] prod;
    int                sh;
    opb = use_imm ? imm : b;
    sh = int'(opb % XLEN);
    prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    r = a;
    case (op)
      exec_pkg::OP_ADD:   r = a + opb;
      exec_pkg::OP_SUB:   r = a + ~opb + 1'b1;
      exec_pkg::OP_AND:   r = a & opb;
      exec_pkg::OP_OR:    r = a | opb;
      exec_pkg::OP_XOR:   r = a ^ opb;
      exec_pkg::OP_SLL:   r = a << sh;
      exec_pkg::OP_SRL:   r = a >> sh;
      exec_pkg::OP_SRA: begin
        for (int i = 0; i < sh; i++) begin
          r = {r[XLEN-1], r[XLEN-1:1]};
        end
      end
      // Flipped sign bits turn a signed compare into an unsigned one.
      exec_pkg::OP_SLT:   r = XLEN'({~a[XLEN-1], a[XLEN-2:0]} < {~opb[XLEN-1], opb[XLEN-2:0]});
      exec_pkg::OP_SLTU:  r = XLEN'(a < opb);
      exec_pkg::OP_LUI:   r = imm;
      exec_pkg::OP_AUIPC: r = pc + imm;
      exec_pkg::OP_LINK:  r = npc;
      exec_pkg::OP_MUL:   r = prod[XLEN-1:0];
      exec_pkg::OP_MULHU: r = prod[2*XLEN-1:XLEN];
      exec_pkg::OP_DIVU:  r = (b == '0) ? '1 : a / b;
      exec_pkg::OP_REMU:  r = (b == '0) ? a : a % b;
      default:            r = '0;
    endcase
    return r;
  endfunction

  task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: out_wdata is %h, expected %h", got, exp);
    end
  endtask

  task automatic check_addr(input exec_pkg::reg_addr_t got, input exec_pkg::reg_addr_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: out_waddr is %h, expected %h", got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    out_ready <= random_ready ? 1'(rand_bits(1)) : 1'b1;
  endtask

  task automatic send(input exec_pkg::exec_op_t op, input logic use_imm,
                      input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                      input logic [XLEN-1:0] imm, input exec_pkg::reg_addr_t waddr);
    logic [XLEN-1:0] pc;
    pc = XLEN'(rand_bits(XLEN)) & ~XLEN'(3);
    tick();
    in_valid <= 1'b1;
    in_op <= op;
    in_use_imm <= use_imm;
    in_rdata1 <= a;
    in_rdata2 <= b;
    in_imm <= imm;
    in_pc <= pc;
    in_npc <= pc + XLEN'(4);
    in_waddr <= waddr;
    @(negedge clk);
    while (!in_ready) begin
      tick();
      @(negedge clk);
    end
    exp_data.push_back(ref_result(op, use_imm, a, b, imm, pc, pc + XLEN'(4)));
    exp_addr.push_back(waddr);
    exp_wren.push_back(waddr != '0);
  endtask

  task automatic drain(input string name, input int n, input int errs_before);
    tick();
    in_valid <= 1'b0;
    while (exp_data.size() != 0) begin
      tick();
    end
    $display("%-12s %0d instructions, %0d errors", name, n, errors - errs_before);
  endtask

  // Checks every output transfer and the stall while mul/div runs.
  always @(negedge clk) begin
    if (rst) begin
      if (md_busy && out_valid) begin
        md_busy = 1'b0;
      end
      if (md_busy && in_ready) begin
        errors++;
        $display("in_ready was high while a mul/div result was still pending");
      end
      if (in_valid && in_ready && exec_pkg::is_muldiv(in_op)) begin
        md_busy = 1'b1;
      end
      if (out_valid && out_ready) begin
        if (exp_data.size() == 0) begin
          errors++;
          $display("A result left the stage with no instruction outstanding");
        end else begin
          check_data(out_wdata, exp_data.pop_front());
          check_addr(out_waddr, exp_addr.pop_front());
          check_flag("out_wren", out_wren, exp_wren.pop_front());
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d results missing", WATCHDOG_NS,
             exp_data.size());
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int                 errs;
    exec_pkg::exec_op_t op;
    logic [XLEN-1:0]    a;
    rst = 1'b0;
    in_valid = 1'b0;
    in_op = exec_pkg::OP_ADD;
    in_use_imm = 1'b0;
    in_rdata1 = '0;
    in_rdata2 = '0;
    in_imm = '0;
    in_pc = '0;
    in_npc = '0;
    in_waddr = '0;
    out_ready = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_flag("in_ready", in_ready, 1'b1);
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("out_wren", out_wren, 1'b0);

    errs = errors;
    for (int i = 0; i < N_ALU; i++) begin
      op = exec_pkg::exec_op_t'(rand_bits(4) % 10);
      send(op, 1'(rand_bits(1)), XLEN'(rand_bits(XLEN)), XLEN'(rand_bits(XLEN)),
           XLEN'(rand_bits(XLEN)), 5'(rand_bits(5)));
    end
    drain("alu", N_ALU, errs);

    errs = errors;
    for (int i = 0; i < N_UPPER; i++) begin
      op = exec_pkg::OP_LUI + exec_pkg::exec_op_t'(i % 3);
      send(op, 1'b1, XLEN'(rand_bits(XLEN)), XLEN'(rand_bits(XLEN)),
           XLEN'(rand_bits(XLEN)), 5'(rand_bits(5)));
    end
    drain("upper_link", N_UPPER, errs);

    errs = errors;
    for (int i = 0; i < N_MUL - 2; i++) begin
      op = (i % 2 == 0) ? exec_pkg::OP_MUL : exec_pkg::OP_MULHU;
      send(op, 1'b0, XLEN'(rand_bits(XLEN)), XLEN'(rand_bits(XLEN)), '0, 5'(rand_bits(5)));
    end
    send(exec_pkg::OP_MUL, 1'b0, '1, '1, '0, 5'd3);
    send(exec_pkg::OP_MULHU, 1'b0, '1, '1, '0, 5'd4);
    drain("mul", N_MUL, errs);

    errs = errors;
    for (int i = 0; i < N_DIV - 2; i++) begin
      op = (i % 2 == 0) ? exec_pkg::OP_DIVU : exec_pkg::OP_REMU;
      send(op, 1'b0, XLEN'(rand_bits(XLEN)), XLEN'(rand_bits(XLEN / 2 + i)), '0,
           5'(rand_bits(5)));
    end
    a = XLEN'(rand_bits(XLEN));
    send(exec_pkg::OP_DIVU, 1'b0, a, '0, '0, 5'd9); // Divide by zero.
    send(exec_pkg::OP_REMU, 1'b0, a, '0, '0, 5'd10);
    drain("div", N_DIV, errs);

    errs = errors;
    send(exec_pkg::OP_ADD, 1'b0, XLEN'(rand_bits(XLEN)), XLEN'(rand_bits(XLEN)), '0, 5'd0);
    send(exec_pkg::OP_ADD, 1'b0, XLEN'(rand_bits(XLEN)), XLEN'(rand_bits(XLEN)), '0, 5'd5);
    send(exec_pkg::OP_MUL, 1'b0, XLEN'(rand_bits(XLEN)), XLEN'(rand_bits(XLEN)), '0, 5'd0);
    send(exec_pkg::OP_MUL, 1'b0, XLEN'(rand_bits(XLEN)), XLEN'(rand_bits(XLEN)), '0, 5'd7);
    drain("x0_dest", N_X0, errs);

    errs = errors;
    random_ready = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      if (rand_bits(2) == 0) begin
        op = exec_pkg::OP_MUL + exec_pkg::exec_op_t'(rand_bits(2));
      end else begin
        op = exec_pkg::exec_op_t'(rand_bits(4) % 13);
      end
      send(op, 1'(rand_bits(1)), XLEN'(rand_bits(XLEN)), XLEN'(rand_bits(XLEN)),
           XLEN'(rand_bits(XLEN)), 5'(rand_bits(5)));
    end
    drain("backpressure", N_BP, errs);

    $display("Checks: %0d, errors: %0d", n_checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
